// ==== source/input_cfg.svh ====
/* input front end constants: frame and debounce lengths, grid bound,
   start position and button bit positions */
`ifndef INPUT_CFG_SVH
`define INPUT_CFG_SVH

// clock cycles per game frame, and the frame counter width
`define FRAME_CYCLES     64
`define FRAME_CNT_W      6

// stable synchronized samples needed to accept a new level
`define DEBOUNCE_CYCLES  8
`define DEBOUNCE_CNT_W   3

// square grid, both axes run 0..COORD_MAX
`define COORD_MAX        15
`define START_X          7
`define START_Y          7

// bit positions inside a button vector
`define BTN_UP           0
`define BTN_DOWN         1
`define BTN_LEFT         2
`define BTN_RIGHT        3
`define BTN_ACTION       4

`endif

// ==== source/input_pkg.sv ====
/* input_pkg: shared types for the controller input front end,
   button vectors, frame snapshots, player coordinates and phases */
`default_nettype none

package input_pkg;

    // one bit per button, bit 0 is up
    // order up, down, left, right, action
    typedef logic [4:0] button_t;

    // frame snapshot word
    // upper half holds pressed events, lower half released events
    typedef logic [9:0] control_t;

    // player position on either axis
    typedef logic [7:0] coord_t;

    // action press count, wraps past 255
    typedef logic [7:0] count_t;

    // player update sequence
    // each phase names the update made on the edge that enters it
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        MOVE = 2'd1,
        ACT  = 2'd2
    } player_phase_t;

endpackage : input_pkg

`default_nettype wire

// ==== source/button_debounce.sv ====
/* button_debounce: two-flop synchronizer and per-button stability counter
   turning raw asynchronous buttons into clean levels */
`default_nettype none
`include "input_cfg.svh"

module button_debounce
    import input_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire button_t buttons,
    output button_t      clean_buttons
);

    // synchronizer stages for the raw inputs
    button_t sync_q1;
    button_t sync_q2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= buttons;
            sync_q2 <= sync_q1;
        end
    end

    // one stability counter per button
    for (genvar i = 0; i < $bits(button_t); i++) begin : g_btn
        logic [`DEBOUNCE_CNT_W-1:0] stable_cnt;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                stable_cnt       <= '0;
                clean_buttons[i] <= 1'b0;
            end else if (sync_q2[i] == clean_buttons[i]) begin
                // sample agrees with clean level, any pending change is dropped
                stable_cnt <= '0;
            end else if (stable_cnt == `DEBOUNCE_CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
                // new level held for DEBOUNCE_CYCLES samples, accept it
                stable_cnt       <= '0;
                clean_buttons[i] <= sync_q2[i];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end

        // an accepted level was already sampled DEBOUNCE_CYCLES cycles back
        assert property (@(posedge clk) disable iff (!rst_n)
            (clean_buttons[i] != $past(clean_buttons[i]))
                |-> ($past(sync_q2[i], `DEBOUNCE_CYCLES) == clean_buttons[i]));
    end

endmodule : button_debounce

`default_nettype wire

// ==== source/frame_timer.sv ====
/* frame_timer: free-running frame counter with a one-cycle strobe
   every FRAME_CYCLES clocks */
`default_nettype none
`include "input_cfg.svh"

module frame_timer (
    input  wire logic clk,
    input  wire logic rst_n,
    output logic      frame_strobe
);

    logic [`FRAME_CNT_W-1:0] frame_cnt;

    // strobe is registered on the wrap, first one FRAME_CYCLES after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt    <= '0;
            frame_strobe <= 1'b0;
        end else if (frame_cnt == `FRAME_CNT_W'(`FRAME_CYCLES - 1)) begin
            frame_cnt    <= '0;
            frame_strobe <= 1'b1;
        end else begin
            frame_cnt    <= frame_cnt + 1'b1;
            frame_strobe <= 1'b0;
        end
    end

    // strobe is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n)
        frame_strobe |=> !frame_strobe);

endmodule : frame_timer

`default_nettype wire

// ==== source/input_collector.sv ====
/* input_collector: records every press and release between frame strobes
   and publishes the collected events as a snapshot at each strobe */
`default_nettype none

module input_collector
    import input_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire button_t clean_buttons,
    input  wire logic    frame_strobe,
    output control_t     snapshot,
    output logic         snapshot_valid
);

    button_t  current_q;
    button_t  previous_q;
    button_t  pressed_q;
    button_t  released_q;
    control_t accum_q;
    control_t accum_next;

    // edge detection, events land two cycles after the clean edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_q  <= '0;
            previous_q <= '0;
            pressed_q  <= '0;
            released_q <= '0;
        end else begin
            current_q  <= clean_buttons;
            previous_q <= current_q;
            // rising edge is a press, falling edge a release
            pressed_q  <= current_q & ~previous_q;
            released_q <= ~current_q & previous_q;
        end
    end

    // events seen in the strobe cycle still belong to the closing frame
    assign accum_next = accum_q | {pressed_q, released_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accum_q        <= '0;
            snapshot       <= '0;
            snapshot_valid <= 1'b0;
        end else begin
            snapshot_valid <= frame_strobe;
            if (frame_strobe) begin
                // publish and start the next frame empty
                snapshot <= accum_next;
                accum_q  <= '0;
            end else begin
                accum_q <= accum_next;
            end
        end
    end

    // snapshot only moves with a valid pulse and is held for the whole frame
    assert property (@(posedge clk) disable iff (!rst_n)
        !snapshot_valid |-> $stable(snapshot));

endmodule : input_collector

`default_nettype wire

// ==== source/player_state.sv ====
/* player_state: applies each frame snapshot to the player, moving a cursor
   on a bounded grid and counting action presses */
`default_nettype none
`include "input_cfg.svh"

module player_state
    import input_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire control_t snapshot,
    input  wire logic     snapshot_valid,
    output coord_t        player_x,
    output coord_t        player_y,
    output count_t        action_count
);

    player_phase_t phase;
    button_t       pressed;
    coord_t        x_next;
    coord_t        y_next;

    // only the pressed half moves the player, releases are ignored
    assign pressed = snapshot[$bits(control_t)-1 -: $bits(button_t)];

    // x axis, opposite presses cancel, saturate at both edges
    always_comb begin
        x_next = player_x;
        if (pressed[`BTN_RIGHT] && !pressed[`BTN_LEFT]) begin
            if (player_x != coord_t'(`COORD_MAX))
                x_next = player_x + 1'b1;
        end else if (pressed[`BTN_LEFT] && !pressed[`BTN_RIGHT]) begin
            if (player_x != '0)
                x_next = player_x - 1'b1;
        end
    end

    // y axis, up counts upward
    always_comb begin
        y_next = player_y;
        if (pressed[`BTN_UP] && !pressed[`BTN_DOWN]) begin
            if (player_y != coord_t'(`COORD_MAX))
                y_next = player_y + 1'b1;
        end else if (pressed[`BTN_DOWN] && !pressed[`BTN_UP]) begin
            if (player_y != '0)
                y_next = player_y - 1'b1;
        end
    end

    // position is written entering MOVE, count entering ACT
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase        <= IDLE;
            player_x     <= coord_t'(`START_X);
            player_y     <= coord_t'(`START_Y);
            action_count <= '0;
        end else begin
            case (phase)
                IDLE: begin
                    if (snapshot_valid) begin
                        player_x <= x_next;
                        player_y <= y_next;
                        phase    <= MOVE;
                    end
                end
                MOVE: begin
                    // snapshot is held all frame, still safe to read here
                    if (pressed[`BTN_ACTION])
                        action_count <= action_count + 1'b1;
                    phase <= ACT;
                end
                ACT:     phase <= IDLE;
                default: phase <= IDLE;
            endcase
        end
    end

    // cursor stays on the grid
    assert property (@(posedge clk) disable iff (!rst_n)
        (player_x <= coord_t'(`COORD_MAX)) && (player_y <= coord_t'(`COORD_MAX)));

    // next frame pulse must find the update sequence finished
    assert property (@(posedge clk) disable iff (!rst_n)
        snapshot_valid |-> (phase == IDLE));

endmodule : player_state

`default_nettype wire

// ==== source/game_input_top.sv ====
/* game_input_top: controller input front end, debounce, frame timing,
   event collection and player state */
`default_nettype none

module game_input_top
    import input_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire button_t buttons,
    output control_t     snapshot,
    output logic         snapshot_valid,
    output coord_t       player_x,
    output coord_t       player_y,
    output count_t       action_count
);

    // debounced button levels
    button_t clean_buttons;
    // one pulse per frame
    logic    frame_strobe;

    button_debounce u_debounce (
        .clk           (clk),
        .rst_n         (rst_n),
        .buttons       (buttons),
        .clean_buttons (clean_buttons)
    );

    frame_timer u_frame_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_strobe (frame_strobe)
    );

    input_collector u_collector (
        .clk            (clk),
        .rst_n          (rst_n),
        .clean_buttons  (clean_buttons),
        .frame_strobe   (frame_strobe),
        .snapshot       (snapshot),
        .snapshot_valid (snapshot_valid)
    );

    // consumes the snapshot in the pulse cycle, no back-pressure
    player_state u_player (
        .clk            (clk),
        .rst_n          (rst_n),
        .snapshot       (snapshot),
        .snapshot_valid (snapshot_valid),
        .player_x       (player_x),
        .player_y       (player_y),
        .action_count   (action_count)
    );

endmodule : game_input_top

`default_nettype wire

// ==== dv/game_input_tb.sv ====
/* game_input_tb: frame-by-frame testbench for the controller input front end,
   scripted and random button vectors checked against a reference model */
`default_nettype none
`include "input_cfg.svh"

module game_input_tb
    import input_pkg::*;
();

    logic     clk = 1'b0;
    logic     rst_n;
    button_t  buttons;
    control_t snapshot;
    logic     snapshot_valid;
    coord_t   player_x;
    coord_t   player_y;
    count_t   action_count;

    // per-frame schedule, index k is the vector held during frame k
    button_t  held_q[$];
    button_t  glitch_q[$];
    int       glen_q[$];
    bit       schedule_ready = 1'b0;
    bit       count_wrapped = 1'b0;

    always #2 clk = ~clk;

    game_input_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .buttons        (buttons),
        .snapshot       (snapshot),
        .snapshot_valid (snapshot_valid),
        .player_x       (player_x),
        .player_y       (player_y),
        .action_count   (action_count)
    );

    // events between two held vectors, presses high and releases low
    function automatic control_t expected_control(button_t prev, button_t next);
        button_t pressed;
        button_t released;
        pressed  = next & ~prev;
        released = prev & ~next;
        return {pressed, released};
    endfunction

    // player rules, returns {x, y, count}
    function automatic logic [23:0] next_player(coord_t x, coord_t y, count_t cnt,
                                                control_t ctrl);
        button_t p;
        int      nx;
        int      ny;
        count_t  ncnt;
        p  = ctrl[9:5];
        // opposite presses give a zero step
        nx = int'(x) + int'(p[`BTN_RIGHT]) - int'(p[`BTN_LEFT]);
        ny = int'(y) + int'(p[`BTN_UP]) - int'(p[`BTN_DOWN]);
        if (nx < 0) nx = 0;
        if (nx > `COORD_MAX) nx = `COORD_MAX;
        if (ny < 0) ny = 0;
        if (ny > `COORD_MAX) ny = `COORD_MAX;
        ncnt = cnt + count_t'(p[`BTN_ACTION]);
        return {coord_t'(nx), coord_t'(ny), ncnt};
    endfunction

    task automatic check_control(input string name, input control_t got, input control_t exp_v);
        if (got !== exp_v) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp_v);
            $display("tests failed");
            $fatal(1, "snapshot mismatch");
        end
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t exp_v);
        if (got !== exp_v) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp_v);
            $display("tests failed");
            $fatal(1, "coordinate mismatch");
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp_v);
        if (got !== exp_v) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp_v);
            $display("tests failed");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp_v);
        if (got !== exp_v) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp_v);
            $display("tests failed");
            $fatal(1, "pulse mismatch");
        end
    endtask

    task automatic add_frame(input button_t held, input button_t gmask, input int glen);
        held_q.push_back(held);
        glitch_q.push_back(gmask);
        glen_q.push_back(glen);
    endtask

    // press in one frame, release in the next
    task automatic add_tap(input button_t b);
        add_frame(b, '0, 0);
        add_frame('0, '0, 0);
    endtask

    task automatic build_schedule();
        button_t v;
        // frame 0, buttons idle through reset
        add_frame('0, '0, 0);
        for (int b = `BTN_UP; b <= `BTN_RIGHT; b++)
            add_tap(button_t'(1 << b));
        // push into every edge and past it
        repeat (9) add_tap(button_t'(1 << `BTN_RIGHT));
        repeat (17) add_tap(button_t'(1 << `BTN_LEFT));
        repeat (9) add_tap(button_t'(1 << `BTN_UP));
        repeat (17) add_tap(button_t'(1 << `BTN_DOWN));
        // back off the corner so cancelling presses are visible
        repeat (3) add_tap(button_t'((1 << `BTN_RIGHT) | (1 << `BTN_UP)));
        add_tap(button_t'((1 << `BTN_LEFT) | (1 << `BTN_RIGHT)));
        add_tap(button_t'((1 << `BTN_UP) | (1 << `BTN_DOWN)));
        repeat (110) add_tap(button_t'(1 << `BTN_ACTION));
        // short pulses on each button, lengths 1 to DEBOUNCE_CYCLES-2
        for (int b = 0; b < $bits(button_t); b++)
            add_frame('0, button_t'(1 << b), 1 + (b % (`DEBOUNCE_CYCLES - 2)));
        add_frame('0, '1, `DEBOUNCE_CYCLES - 2);
        // low-going glitch on a held button
        add_frame(button_t'(1 << `BTN_ACTION), '0, 0);
        add_frame(button_t'(1 << `BTN_ACTION), button_t'(1 << `BTN_ACTION),
                  `DEBOUNCE_CYCLES - 2);
        add_frame('0, '0, 0);
        for (int i = 0; i < 300; i++) begin
            v = button_t'($urandom);
            // action toggles every frame so the count wraps in this run
            v[`BTN_ACTION] = ~held_q[held_q.size() - 1][`BTN_ACTION];
            add_frame(v, '0, 0);
        end
    endtask

    // returns 1 time unit after the edge that raised snapshot_valid
    task automatic wait_snapshot();
        do begin
            @(posedge clk);
            #1;
        end while (snapshot_valid !== 1'b1);
    endtask

    // valid pulses one cycle after each strobe, first strobe a frame after reset
    task automatic check_pulses();
        int cyc;
        cyc = 0;
        forever begin
            @(posedge clk);
            #1;
            cyc++;
            check_flag("snapshot_valid", snapshot_valid,
                       (cyc > `FRAME_CYCLES) && ((cyc - 1) % `FRAME_CYCLES == 0));
        end
    endtask

    task automatic drive_frames();
        for (int k = 1; k < held_q.size(); k++) begin
            wait_snapshot();
            repeat (2) @(posedge clk);
            #1;
            if (glitch_q[k] != '0) begin
                buttons = held_q[k] ^ glitch_q[k];
                repeat (glen_q[k]) @(posedge clk);
                #1;
            end
            buttons = held_q[k];
        end
    endtask

    task automatic check_frames();
        coord_t      x;
        coord_t      y;
        count_t      cnt;
        control_t    exp_ctrl;
        button_t     prev;
        logic [23:0] nxt;
        x    = coord_t'(`START_X);
        y    = coord_t'(`START_Y);
        cnt  = '0;
        prev = '0;
        for (int k = 0; k < held_q.size(); k++) begin
            wait_snapshot();
            exp_ctrl = expected_control(prev, held_q[k]);
            check_control("snapshot", snapshot, exp_ctrl);
            // player outputs still hold the previous frame's result here
            check_coord("player_x", player_x, x);
            check_coord("player_y", player_y, y);
            check_count("action_count", action_count, cnt);
            nxt = next_player(x, y, cnt, exp_ctrl);
            if (cnt == 8'hff && nxt[7:0] == 8'h00)
                count_wrapped = 1'b1;
            {x, y, cnt} = nxt;
            prev = held_q[k];
        end
        // last update needs two cycles to settle
        repeat (3) @(posedge clk);
        #1;
        check_coord("player_x", player_x, x);
        check_coord("player_y", player_y, y);
        check_count("action_count", action_count, cnt);
    endtask

    initial begin
        rst_n   = 1'b0;
        buttons = '0;
        void'($urandom(40));
        build_schedule();
        schedule_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            check_pulses();
        join_none
        fork
            drive_frames();
            check_frames();
        join
        if (!count_wrapped) begin
            $display("action_count never wrapped past 255 during the run");
            $display("tests failed");
            $fatal(1, "count wrap not reached");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    // bound on the whole run, four spare frames cover reset and the tail
    initial begin
        wait (schedule_ready);
        #((held_q.size() + 4) * `FRAME_CYCLES * 4);
        $display("timeout, no snapshot arrived in time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule : game_input_tb

`default_nettype wire

// ==== src.f ====
+incdir+source
source/input_pkg.sv
source/button_debounce.sv
source/frame_timer.sv
source/input_collector.sv
source/player_state.sv
source/game_input_top.sv
dv/game_input_tb.sv

// ==== Makefile ====
# Verilator build and run for the controller input front end

TOP := game_input_tb

.PHONY: all lint clean

# build, run, and pass only when the pass message shows up
all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

obj_dir/V$(TOP): src.f source/*.sv source/*.svh dv/*.sv
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
